// File: data_access.sv
`timescale 1ns/1ps
`default_nettype none

module data_access
    import rv_mem_pkg::*;
(
    input  wire                clk,
    input  wire dmem_type_e    dmem_type_i,  // Access kind this cycle
    input  wire [XLEN-1:0]     addr_i,       // Byte address from the ALU
    input  wire [XLEN-1:0]     store_data_i, // Unsteered rs2 value
    output logic [XLEN-1:0]    rd_word_o     // Whole word, one cycle late
);

    logic               mem_en;    // Any load or store
    logic               wr_en;     // Store only
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN/8-1:0]  byte_en;   // One bit per byte lane
    mem_word_u          wr_word;   // Steered store data

    logic [XLEN-1:0]    mem [DMEM_WORDS];

    // ******************************
    // Access decode
    // ******************************
    assign word_addr = addr_i[DMEM_AW+1:2]; // Drop the byte offset
    assign mem_en    = (dmem_type_i != DMEM_NONE);
    assign wr_en     = (dmem_type_i == DMEM_SB) ||
                       (dmem_type_i == DMEM_SH) ||
                       (dmem_type_i == DMEM_SW);

    // ******************************
    // Store lane steering
    // ******************************
    // Lanes outside the mask carry zero, the mask keeps them unwritten
    always_comb begin
        wr_word = '0;
        byte_en = '0;
        case (dmem_type_i)
            DMEM_SB: begin
                wr_word.bytes[addr_i[1:0]] = store_data_i[7:0];
                byte_en[addr_i[1:0]]       = 1'b1; // One-hot lane
            end
            DMEM_SH: begin
                // Only bit 1 picks the half
                wr_word.halves[addr_i[1]] = store_data_i[15:0];
                byte_en = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            DMEM_SW: begin
                wr_word = store_data_i;
                byte_en = '1;
            end
            default: begin
                // Loads and bubbles, nothing to steer
                wr_word = '0;
                byte_en = '0;
            end
        endcase
    end

    // ******************************
    // Byte-writable array
    // ******************************
    // Synchronous port, write at the edge, read word registered
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (wr_en) begin
                for (int i = 0; i < XLEN/8; i++) begin
                    if (byte_en[i]) begin
                        mem[word_addr][i*8 +: 8] <= wr_word.bytes[i];
                    end
                end
            end else begin
                rd_word_o <= mem[word_addr]; // Load path
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_stage.f
rv_mem_pkg.sv
rv_wb_pkg.sv
mem_wb_if.sv
data_access.sv
wb_pipe_reg.sv
writeback_merge.sv
mem_stage.sv
mem_stage_asserts.sv
tb_mem_stage.sv

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import rv_mem_pkg::*, rv_wb_pkg::*;
(
    input  wire                clk,
    input  wire                resetn,
    // Execute bundle
    input  wire [XLEN-1:0]     alu_result_i,
    input  wire [XLEN-1:0]     store_data_i,
    input  wire [XLEN-1:0]     ext_imm_i,
    input  wire [XLEN-1:0]     pc_plus_i,
    input  wire [3:0]          dmem_type_i,
    input  wire [3:0]          result_src_i,
    input  wire                reg_write_en_i,
    input  wire [REG_AW-1:0]   rd_idx_i,
    // Write-back result
    output logic [XLEN-1:0]    wb_data_o,
    output logic [REG_AW-1:0]  rd_idx_o,
    output logic               reg_write_en_o
);

    dmem_type_e      dmem_type;  // Typed view of the raw code
    result_src_e     result_src;
    logic [XLEN-1:0] rd_word;    // Memory word, one cycle after the address

    assign dmem_type  = dmem_type_e'(dmem_type_i);
    assign result_src = result_src_e'(result_src_i);

    mem_wb_if wb_if ();

    // ******************************
    // Memory and pipeline register
    // ******************************
    // Both update at the same edge, so the word and its fields stay paired
    data_access u_data_access (
        .clk          (clk),
        .dmem_type_i  (dmem_type),
        .addr_i       (alu_result_i),
        .store_data_i (store_data_i),
        .rd_word_o    (rd_word)
    );

    wb_pipe_reg u_wb_pipe_reg (
        .clk            (clk),
        .resetn         (resetn),
        .alu_result_i   (alu_result_i),
        .ext_imm_i      (ext_imm_i),
        .pc_plus_i      (pc_plus_i),
        .reg_write_en_i (reg_write_en_i),
        .rd_idx_i       (rd_idx_i),
        .result_src_i   (result_src),
        .dmem_type_i    (dmem_type),
        .wb             (wb_if.source)
    );

    // ******************************
    // Write-back merge
    // ******************************
    writeback_merge u_writeback_merge (
        .wb             (wb_if.sink),
        .rd_word_i      (rd_word),
        .wb_data_o      (wb_data_o),
        .rd_idx_o       (rd_idx_o),
        .reg_write_en_o (reg_write_en_o)
    );

endmodule

`default_nettype wire

// File: mem_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_asserts
    import rv_mem_pkg::*;
(
    input wire        clk,
    input wire        resetn,
    input wire [3:0]  dmem_type_i,    // Raw access code at the top
    input wire [3:0]  byte_en_i,      // Lane mask inside data_access
    input wire        reg_write_en_i  // Top-level RF write enable
);

    int unsigned fail_count = 0; // Failed assertions so far

    // ******************************
    // Store byte enables
    // ******************************
    property p_sb_onehot;
        @(posedge clk) disable iff (!resetn)
            (dmem_type_i == DMEM_SB) |-> $onehot(byte_en_i);
    endproperty

    // Only the low or the high half, never a mix
    property p_sh_half_mask;
        @(posedge clk) disable iff (!resetn)
            (dmem_type_i == DMEM_SH) |-> (byte_en_i == 4'b0011 || byte_en_i == 4'b1100);
    endproperty

    // ******************************
    // Reset behavior
    // ******************************
    property p_no_write_after_reset;
        @(posedge clk) !resetn |=> !reg_write_en_i;
    endproperty

    a_sb_onehot:       assert property (p_sb_onehot)
        else begin
            $error("byte store enable is not one-hot: %b", byte_en_i);
            fail_count++;
        end
    a_sh_half_mask:    assert property (p_sh_half_mask)
        else begin
            $error("half store enable is not a half mask: %b", byte_en_i);
            fail_count++;
        end
    a_no_write_reset:  assert property (p_no_write_after_reset)
        else begin
            $error("register write enable high in the cycle after reset");
            fail_count++;
        end

endmodule

// Lane mask is taken from the data_access instance inside the top
bind mem_stage mem_stage_asserts u_mem_stage_asserts (
    .clk            (clk),
    .resetn         (resetn),
    .dmem_type_i    (dmem_type_i),
    .byte_en_i      (u_data_access.byte_en),
    .reg_write_en_i (reg_write_en_o)
);

`default_nettype wire

// File: mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// Registered bundle between the pipeline register and the write-back mux
interface mem_wb_if
    import rv_mem_pkg::*, rv_wb_pkg::*;
();

    logic [XLEN-1:0]   alu_result;   // Also the byte address
    logic [XLEN-1:0]   ext_imm;
    logic [XLEN-1:0]   pc_plus;
    logic              reg_write_en;
    logic [REG_AW-1:0] rd_idx;
    result_src_e       result_src;
    dmem_type_e        mem_op;       // Access type, lined up with read data
    logic [1:0]        byte_off;     // addr[1:0] of the access

    // Register side
    modport source (
        output alu_result, ext_imm, pc_plus,
        output reg_write_en, rd_idx, result_src,
        output mem_op, byte_off
    );

    // Merge side
    modport sink (
        input alu_result, ext_imm, pc_plus,
        input reg_write_en, rd_idx, result_src,
        input mem_op, byte_off
    );

endinterface

`default_nettype wire

// File: rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // ******************************
    // Word and memory geometry
    // ******************************
    localparam int XLEN       = 32;   // Data word width
    localparam int DMEM_WORDS = 1024; // Depth in words
    localparam int DMEM_AW    = 10;   // Word address, taken from addr[11:2]

    // ******************************
    // Load/store type codes
    // ******************************
    // Code 0 marks a bubble or any op that leaves memory alone
    typedef enum logic [3:0] {
        DMEM_NONE = 4'd0,
        DMEM_LB   = 4'd1, // Load byte, signed
        DMEM_LH   = 4'd2, // Load half, signed
        DMEM_LW   = 4'd3, // Load word
        DMEM_LBU  = 4'd4, // Load byte, unsigned
        DMEM_LHU  = 4'd5, // Load half, unsigned
        DMEM_SB   = 4'd6, // Store byte
        DMEM_SH   = 4'd7, // Store half
        DMEM_SW   = 4'd8  // Store word
    } dmem_type_e;

    // ******************************
    // Memory word views
    // ******************************
    // Same 32 bits, decoded per byte lane or per half
    // Store steering writes through it, load extraction reads through it
    typedef union packed {
        logic [XLEN/8-1:0][7:0]   bytes;  // Lane i holds bits 8i+7:8i
        logic [XLEN/16-1:0][15:0] halves; // Half 1 is bits 31:16
    } mem_word_u;

endpackage

`default_nettype wire

// File: rv_wb_pkg.sv
`default_nettype none

package rv_wb_pkg;

    // ******************************
    // Register file geometry
    // ******************************
    localparam int REG_AW = 5; // x0..x31

    // ******************************
    // Write-back source select
    // ******************************
    // One-hot, one bit per source
    typedef enum logic [3:0] {
        RES_ALU = 4'b0001, // ALU result, also the reset choice
        RES_MEM = 4'b0010, // Extended load data
        RES_IMM = 4'b0100, // Extended immediate, for lui
        RES_PC  = 4'b1000  // pc+4, for jal and jalr
    } result_src_e;

endpackage

`default_nettype wire

// File: tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
    import rv_mem_pkg::*, rv_wb_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;   // Inputs change after the edge
    // Bundle budget per test, with some slack
    localparam int N_RESET = 8;
    localparam int N_WORD  = 48;
    localparam int N_BYTE  = 48;
    localparam int N_HALF  = 48;
    localparam int N_SRC   = 16;
    localparam int N_RAND  = 64 + 300 + 8;
    localparam int TOTAL_BUNDLES = N_RESET + N_WORD + N_BYTE + N_HALF + N_SRC + N_RAND;
    localparam int TIMEOUT_NS    = (TOTAL_BUNDLES + 100) * CLK_PERIOD;

    logic              clk;
    logic              resetn;
    logic [XLEN-1:0]   alu_result_i;
    logic [XLEN-1:0]   store_data_i;
    logic [XLEN-1:0]   ext_imm_i;
    logic [XLEN-1:0]   pc_plus_i;
    logic [3:0]        dmem_type_i;
    logic [3:0]        result_src_i;
    logic              reg_write_en_i;
    logic [REG_AW-1:0] rd_idx_i;
    wire  [XLEN-1:0]   wb_data_o;
    wire  [REG_AW-1:0] rd_idx_o;
    wire               reg_write_en_o;

    logic [XLEN-1:0]   shadow [DMEM_WORDS]; // Model of the data memory
    logic [XLEN-1:0]   exp_data;
    logic [REG_AW-1:0] exp_rd;
    logic              exp_we;
    bit                chk_on;              // Set once reset is released
    bit                pending;             // A bundle awaits its check
    int                err_count;
    int                check_count;
    int                test_count;
    int                test_fail_count;
    int                test_err_start;
    int                assert_fails;        // From the bound checker
    integer            seed;

    mem_stage DUT (
        .clk            (clk),
        .resetn         (resetn),
        .alu_result_i   (alu_result_i),
        .store_data_i   (store_data_i),
        .ext_imm_i      (ext_imm_i),
        .pc_plus_i      (pc_plus_i),
        .dmem_type_i    (dmem_type_i),
        .result_src_i   (result_src_i),
        .reg_write_en_i (reg_write_en_i),
        .rd_idx_i       (rd_idx_i),
        .wb_data_o      (wb_data_o),
        .rd_idx_o       (rd_idx_o),
        .reg_write_en_o (reg_write_en_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    // ******************************
    // Reference model
    // ******************************
    function automatic bit is_load(input logic [3:0] op);
        return op inside {DMEM_LB, DMEM_LH, DMEM_LW, DMEM_LBU, DMEM_LHU};
    endfunction

    // Write-back value for one bundle, word = memory before its edge
    function automatic logic [XLEN-1:0] expected_wb(
        input logic [3:0]      op,
        input logic [XLEN-1:0] addr,
        input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] pc,
        input logic [3:0]      src,
        input logic [XLEN-1:0] word
    );
        logic [XLEN-1:0] shifted;
        logic [7:0]      b;
        logic [15:0]     h;
        logic [XLEN-1:0] ld;
        shifted = word >> (8 * addr[1:0]);
        b = shifted[7:0];
        h = addr[1] ? word[31:16] : word[15:0]; // Half picked by bit 1 alone
        case (op)
            DMEM_LB:  ld = {{24{b[7]}}, b};
            DMEM_LH:  ld = {{16{h[15]}}, h};
            DMEM_LBU: ld = {24'h0, b};
            DMEM_LHU: ld = {16'h0, h};
            default:  ld = word;               // LW
        endcase
        case (src)
            RES_MEM: return ld;
            RES_IMM: return imm;
            RES_PC:  return pc;
            default: return addr;              // ALU result
        endcase
    endfunction

    task automatic update_shadow(
        input logic [3:0] op, input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data
    );
        logic [DMEM_AW-1:0] idx;
        idx = addr[DMEM_AW+1:2];
        case (op)
            DMEM_SB: shadow[idx][8*addr[1:0] +: 8] = data[7:0];
            DMEM_SH: begin
                if (addr[1]) shadow[idx][31:16] = data[15:0];
                else         shadow[idx][15:0]  = data[15:0];
            end
            DMEM_SW: shadow[idx] = data;
            default: ;                         // Loads and bubbles
        endcase
    endtask

    task automatic check(
        input string name, input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp
    );
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch at time %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ******************************
    // Compare process
    // ******************************
    // Expected value fixed at the edge, outputs checked half a cycle later
    always @(posedge clk) begin
        if (chk_on) begin
            exp_data = expected_wb(dmem_type_i, alu_result_i, ext_imm_i, pc_plus_i,
                                   result_src_i, shadow[alu_result_i[DMEM_AW+1:2]]);
            exp_rd   = rd_idx_i;
            exp_we   = reg_write_en_i;
            update_shadow(dmem_type_i, alu_result_i, store_data_i);
            pending  = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (pending) begin
            check("wb_data_o", wb_data_o, exp_data);
            check("rd_idx_o", {{(XLEN-REG_AW){1'b0}}, rd_idx_o},
                  {{(XLEN-REG_AW){1'b0}}, exp_rd});
            check("reg_write_en_o", {{(XLEN-1){1'b0}}, reg_write_en_o},
                  {{(XLEN-1){1'b0}}, exp_we});
        end
    end

    // ******************************
    // Stimulus helpers
    // ******************************
    task automatic send_bundle(
        input logic [3:0]      op,
        input logic [XLEN-1:0] addr,
        input logic [XLEN-1:0] data,
        input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] pc,
        input logic [3:0]      src,
        input logic            we,
        input logic [REG_AW-1:0] rd
    );
        @(posedge clk);
        #DRIVE_DELAY;
        dmem_type_i    = op;
        alu_result_i   = addr;
        store_data_i   = data;
        ext_imm_i      = imm;
        pc_plus_i      = pc;
        result_src_i   = src;
        reg_write_en_i = we;
        rd_idx_i       = rd;
    endtask

    task automatic store_op(input logic [3:0] op, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] data);
        send_bundle(op, addr, data, ~addr, addr + 32'd4, RES_ALU, 1'b0, '0);
    endtask

    task automatic load_op(input logic [3:0] op, input logic [XLEN-1:0] addr,
                           input logic [REG_AW-1:0] rd);
        send_bundle(op, addr, $random(seed), 32'h0, addr + 32'd4, RES_MEM, 1'b1, rd);
    endtask

    task automatic bubble();
        send_bundle(DMEM_NONE, '0, '0, '0, '0, RES_ALU, 1'b0, '0);
    endtask

    // Drain the last bundle, then one summary line
    task automatic report_test(input string name);
        int fails;
        bubble();
        @(posedge clk);
        @(negedge clk);
        #1;
        fails = err_count - test_err_start;
        test_count++;
        if (fails != 0) test_fail_count++;
        $display("test %-16s done, %0d mismatches", name, fails);
        test_err_start = err_count;
    endtask

    // ******************************
    // Tests
    // ******************************
    task automatic run_reset();
        repeat (4) bubble();                   // rd 0, no write
        report_test("reset");
    endtask

    task automatic word_round_trip();
        logic [XLEN-1:0] a;
        for (int i = 0; i < 16; i++) begin
            a = 32'(((i * 67 + 5) % DMEM_WORDS) * 4);
            store_op(DMEM_SW, a, $random(seed));
        end
        for (int i = 0; i < 16; i++) begin
            a = 32'(((i * 67 + 5) % DMEM_WORDS) * 4);
            load_op(DMEM_LW, a, 5'(i + 1));
        end
        for (int k = 0; k < 4; k++) begin      // Load right behind the store
            a = 32'h0000_0F00 + 32'(k * 4);
            store_op(DMEM_SW, a, $random(seed));
            load_op(DMEM_LW, a, 5'd7);
        end
        report_test("word_round_trip");
    endtask

    task automatic byte_lanes();
        logic [XLEN-1:0] base;
        logic [7:0]      bval;
        base = 32'h0000_0400;
        for (int pass = 0; pass < 2; pass++) begin
            store_op(DMEM_SW, base, pass ? 32'hEEDD_CCBB : 32'h1122_3344);
            for (int off = 0; off < 4; off++) begin
                // Top bit clear on the first pass, set on the second
                bval = pass ? (8'h80 | 8'(off * 17)) : (8'h30 + 8'(off));
                store_op(DMEM_SB, base + 32'(off), {24'hDEAD_BE, bval});
                load_op(DMEM_LW, base, 5'd1);  // Other lanes untouched
                load_op(DMEM_LB, base + 32'(off), 5'd2);
                load_op(DMEM_LBU, base + 32'(off), 5'd3);
            end
        end
        report_test("byte_lanes");
    endtask

    task automatic halfword_access();
        logic [XLEN-1:0] hbase;
        logic [15:0]     hval;
        hbase = 32'h0000_0800;
        for (int off = 0; off < 4; off++) begin    // Odd offsets act as even
            for (int pass = 0; pass < 2; pass++) begin
                store_op(DMEM_SW, hbase, 32'hA5A5_5A5A);
                hval = pass ? (16'h8D00 | 16'(off)) : (16'h7B00 | 16'(off));
                store_op(DMEM_SH, hbase + 32'(off), {16'hFFFF, hval});
                load_op(DMEM_LW, hbase, 5'd4);
                load_op(DMEM_LH, hbase + 32'(off), 5'd5);
                load_op(DMEM_LHU, hbase + 32'(off), 5'd6);
            end
        end
        report_test("halfword_access");
    endtask

    task automatic direct_sources();
        logic [3:0]      src;
        logic [XLEN-1:0] r;
        for (int s = 0; s < 3; s++) begin
            src = (s == 0) ? RES_ALU : (s == 1) ? RES_IMM : RES_PC;
            repeat (4) begin
                r = $random(seed);
                send_bundle(DMEM_NONE, $random(seed), '0, $random(seed), $random(seed),
                            src, r[0], r[5:1]);
            end
        end
        report_test("direct_sources");
    endtask

    task automatic random_mix();
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] pick;
        logic [3:0]      op;
        logic [3:0]      src;
        for (int w = 0; w < 64; w++) begin     // No read of unset words
            store_op(DMEM_SW, 32'(w * 4), $random(seed));
        end
        repeat (300) begin
            r    = $random(seed);
            pick = $random(seed);
            op   = 4'(pick % 9);
            if (is_load(op)) begin
                src = RES_MEM;
            end else begin
                src = (r[9:8] == 2'd1) ? RES_IMM : (r[9:8] == 2'd2) ? RES_PC : RES_ALU;
            end
            send_bundle(op, {24'h0, r[5:0], r[7:6]}, $random(seed), $random(seed),
                        $random(seed), src, r[10], r[15:11]);
        end
        report_test("random_mix");
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        seed           = 32'h42d8_ed3a;
        resetn         = 1'b0;
        dmem_type_i    = DMEM_NONE;
        alu_result_i   = '0;
        store_data_i   = '0;
        ext_imm_i      = '0;
        pc_plus_i      = '0;
        result_src_i   = RES_ALU;
        reg_write_en_i = 1'b0;
        rd_idx_i       = '0;
        chk_on         = 1'b0;
        pending        = 1'b0;
        err_count      = 0;
        check_count    = 0;
        test_count     = 0;
        test_fail_count = 0;
        test_err_start = 0;
        assert_fails   = 0;

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        check("reg_write_en_o", {{(XLEN-1){1'b0}}, reg_write_en_o}, '0); // Held in reset
        check("rd_idx_o", {{(XLEN-REG_AW){1'b0}}, rd_idx_o}, '0);
        resetn = 1'b1;
        chk_on = 1'b1;

        run_reset();
        word_round_trip();
        byte_lanes();
        halfword_access();
        direct_sources();
        random_mix();

        assert_fails = DUT.u_mem_stage_asserts.fail_count;
        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assert fails",
                 test_count, test_fail_count, check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the bundle budget
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, run did not finish", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pipe_reg
    import rv_mem_pkg::*, rv_wb_pkg::*;
(
    input  wire                clk,
    input  wire                resetn,
    input  wire [XLEN-1:0]     alu_result_i,   // Result, also the address
    input  wire [XLEN-1:0]     ext_imm_i,
    input  wire [XLEN-1:0]     pc_plus_i,
    input  wire                reg_write_en_i,
    input  wire [REG_AW-1:0]   rd_idx_i,
    input  wire result_src_e   result_src_i,
    input  wire dmem_type_e    dmem_type_i,
    mem_wb_if.source           wb
);

    // ******************************
    // Control fields
    // ******************************
    // Held in step with the memory read, so the merge sees
    // the access type of the word it is handed
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb.reg_write_en <= 1'b0;      // No RF write out of reset
            wb.rd_idx       <= '0;
            wb.result_src   <= RES_ALU;
            wb.mem_op       <= DMEM_NONE; // No load pending
        end else begin
            wb.reg_write_en <= reg_write_en_i;
            wb.rd_idx       <= rd_idx_i;
            wb.result_src   <= result_src_i;
            wb.mem_op       <= dmem_type_i;
        end
    end

    // ******************************
    // Payload fields
    // ******************************
    always_ff @(posedge clk) begin
        wb.alu_result <= alu_result_i;
        wb.ext_imm    <= ext_imm_i;
        wb.pc_plus    <= pc_plus_i;
        wb.byte_off   <= alu_result_i[1:0]; // Lane select for the load
    end

endmodule

`default_nettype wire

// File: writeback_merge.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_merge
    import rv_mem_pkg::*, rv_wb_pkg::*;
(
    mem_wb_if.sink              wb,
    input  wire [XLEN-1:0]      rd_word_i,      // Raw word from memory
    output logic [XLEN-1:0]     wb_data_o,
    output logic [REG_AW-1:0]   rd_idx_o,
    output logic                reg_write_en_o
);

    mem_word_u       rd_u;    // Read word, byte or half view
    logic [7:0]      ld_byte; // Addressed byte
    logic [15:0]     ld_half; // Addressed half
    logic [XLEN-1:0] ld_val;  // Extended load result

    // ******************************
    // Load extraction
    // ******************************
    assign rd_u    = rd_word_i;
    assign ld_byte = rd_u.bytes[wb.byte_off];
    assign ld_half = rd_u.halves[wb.byte_off[1]]; // Offset bit 0 ignored

    always_comb begin
        case (wb.mem_op)
            DMEM_LB:  ld_val = {{(XLEN-8){ld_byte[7]}}, ld_byte};   // Sign
            DMEM_LH:  ld_val = {{(XLEN-16){ld_half[15]}}, ld_half}; // Sign
            DMEM_LBU: ld_val = {{(XLEN-8){1'b0}}, ld_byte};
            DMEM_LHU: ld_val = {{(XLEN-16){1'b0}}, ld_half};
            DMEM_LW:  ld_val = rd_u;
            default:  ld_val = rd_u; // Not a load, value unused
        endcase
    end

    // ******************************
    // Write-back select
    // ******************************
    // Illegal one-hot codes fall back to the ALU result
    always_comb begin
        case (wb.result_src)
            RES_MEM: wb_data_o = ld_val;
            RES_IMM: wb_data_o = wb.ext_imm;
            RES_PC:  wb_data_o = wb.pc_plus;
            default: wb_data_o = wb.alu_result;
        endcase
    end

    // Destination fields, already registered
    assign rd_idx_o       = wb.rd_idx;
    assign reg_write_en_o = wb.reg_write_en;

endmodule

`default_nettype wire
